/* tiny_core.f */
source/isa_pkg.sv
source/core_pkg.sv
source/fetch_unit.sv
source/reg_file.sv
source/alu.sv
source/core_sequencer.sv
source/store_port.sv
source/tiny_core.sv
dv/tiny_core_assertions.sv
dv/tiny_core_tb.sv

/* dv/tiny_core_tb.sv */
`timescale 1ns/1ps

module tiny_core_tb;

    localparam int prog_depth   = 64;
    localparam int halt_timeout = 2000;

    logic                        clear;
    logic                        rst_n;
    logic                        imem_ready;
    logic [core_pkg::data_w-1:0] imem_data;
    logic                        st_ready;
    logic                        imem_valid;
    logic [core_pkg::addr_w-1:0] imem_addr;
    logic                        st_valid;
    logic [core_pkg::addr_w-1:0] st_addr;
    logic [core_pkg::data_w-1:0] st_data;
    logic                        halted;

    logic [31:0] prog [prog_depth];
    int          prog_len;
    string       test_name;
    int          error_count;
    int          errors_at_start;
    int          test_count;
    int          st_stall;
    logic [31:0] test_rng;
    logic [31:0] imem_rng;
    logic [31:0] st_rng;
    logic [15:0] fetch_log [$];
    logic [15:0] st_addr_log [$];
    logic [31:0] st_data_log [$];
    logic [15:0] exp_fetch [$];
    logic [15:0] exp_addr [$];
    logic [31:0] exp_data [$];

    tiny_core u_dut (
        .clear      (clear),
        .rst_n      (rst_n),
        .imem_ready (imem_ready),
        .imem_data  (imem_data),
        .st_ready   (st_ready),
        .imem_valid (imem_valid),
        .imem_addr  (imem_addr),
        .st_valid   (st_valid),
        .st_addr    (st_addr),
        .st_data    (st_data),
        .halted     (halted)
    );

    bind tiny_core tiny_core_assertions u_assert (
        .clear      (clear),
        .rst_n      (rst_n),
        .imem_valid (imem_valid),
        .imem_ready (imem_ready),
        .imem_addr  (imem_addr),
        .st_valid   (st_valid),
        .st_ready   (st_ready),
        .st_addr    (st_addr),
        .st_data    (st_data),
        .halted     (halted),
        .state      (u_seq.state_q)
    );

    initial
    begin
        clear = 1'b0;
        forever
            #10 clear = ~clear;
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rand_word();
        test_rng = lcg(test_rng);
        return test_rng;
    endfunction

    function automatic logic [31:0] encode_reg(input isa_pkg::opcode_e op,
            input logic [2:0] ra, input logic [2:0] rb, input logic [2:0] rd);
        isa_pkg::instr_u w;
        w          = '0;
        w.r.opcode = op;
        w.r.ra     = ra;
        w.r.rb     = rb;
        w.r.rd     = rd;
        return w;
    endfunction

    function automatic logic [31:0] encode_imm(input isa_pkg::opcode_e op,
            input logic [2:0] ra, input logic [2:0] rd, input logic hl, input logic [15:0] imm);
        isa_pkg::instr_u w;
        w          = '0;
        w.i.opcode = op;
        w.i.ra     = ra;
        w.i.rd     = rd;
        w.i.hl     = hl;
        w.i.imm    = imm;
        return w;
    endfunction

    // unused words are halts tagged with their own address
    function automatic logic [31:0] read_prog(input logic [15:0] addr);
        if (addr < prog_depth)
            return prog[addr];
        return encode_imm(isa_pkg::op_halt, 3'd0, 3'd0, 1'b0, addr);
    endfunction

    // instruction memory answers each request after 0 to 3 cycles
    initial
    begin : imem_model
        int   wait_left;
        logic armed;
        imem_ready = 1'b0;
        imem_data  = '0;
        armed      = 1'b0;
        wait_left  = 0;
        forever
        begin
            @(posedge clear);
            if (!rst_n)
            begin
                imem_ready <= 1'b0;
                armed = 1'b0;
            end
            else if (imem_valid && imem_ready)
            begin
                fetch_log.push_back(imem_addr);
                imem_ready <= 1'b0;
                armed = 1'b0;
            end
            else if (imem_valid)
            begin
                if (!armed)
                begin
                    imem_rng  = lcg(imem_rng);
                    wait_left = imem_rng[17:16];
                    armed     = 1'b1;
                end
                if (wait_left == 0)
                begin
                    imem_ready <= 1'b1;
                    imem_data  <= read_prog(imem_addr);
                end
                else
                    wait_left--;
            end
        end
    end

    // st_stall adds a long back-pressure interval to each store
    initial
    begin : store_monitor
        int          wait_left;
        logic        armed;
        logic [15:0] held_addr;
        logic [31:0] held_data;
        st_ready  = 1'b0;
        armed     = 1'b0;
        wait_left = 0;
        forever
        begin
            @(posedge clear);
            if (!rst_n)
            begin
                st_ready <= 1'b0;
                armed = 1'b0;
            end
            else if (st_valid)
            begin
                if (!armed)
                begin
                    st_rng    = lcg(st_rng);
                    wait_left = st_stall + st_rng[17:16];
                    held_addr = st_addr;
                    held_data = st_data;
                    armed     = 1'b1;
                end
                check_value("held st_addr", held_addr, st_addr);
                check_value("held st_data", held_data, st_data);
                if (st_ready)
                begin
                    st_addr_log.push_back(st_addr);
                    st_data_log.push_back(st_data);
                    st_ready <= 1'b0;
                    armed = 1'b0;
                end
                else if (wait_left == 0)
                    st_ready <= 1'b1;
                else
                    wait_left--;
            end
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
            input logic [31:0] actual);
        if (actual !== expected)
        begin
            error_count++;
            $display("error: %s: %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
        prog_len        = 0;
        for (int a = 0; a < prog_depth; a++)
            prog[a] = encode_imm(isa_pkg::op_halt, 3'd0, 3'd0, 1'b0, a[15:0]);
        exp_fetch.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic emit(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    task automatic put_const(input logic [2:0] rd, input logic [31:0] value);
        emit(encode_imm(isa_pkg::op_ldi, 3'd0, rd, 1'b0, value[15:0]));
        emit(encode_imm(isa_pkg::op_ldi, 3'd0, rd, 1'b1, value[31:16]));
    endtask

    task automatic put_store(input logic [2:0] ra, input logic [15:0] addr);
        emit(encode_imm(isa_pkg::op_store, ra, 3'd0, 1'b0, addr));
    endtask

    task automatic put_halt();
        emit(encode_imm(isa_pkg::op_halt, 3'd0, 3'd0, 1'b0, 16'd0));
    endtask

    task automatic expect_store(input logic [15:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // straight-line programs fetch every word once including the halt
    task automatic expect_linear();
        for (int k = 0; k < prog_len; k++)
            exp_fetch.push_back(k[15:0]);
    endtask

    task automatic put_op_store(input isa_pkg::opcode_e op, input logic [2:0] rd,
            input logic [15:0] addr, input logic [31:0] expected);
        emit(encode_reg(op, 3'd1, 3'd2, rd));
        put_store(rd, addr);
        expect_store(addr, expected);
    endtask

    task automatic run_program();
        int cycles;
        @(posedge clear);
        rst_n <= 1'b0;
        repeat (16) @(posedge clear);
        fetch_log.delete();
        st_addr_log.delete();
        st_data_log.delete();
        rst_n <= 1'b1;
        cycles = 0;
        while (!halted && cycles < halt_timeout)
        begin
            @(posedge clear);
            cycles++;
        end
        if (!halted)
        begin
            error_count++;
            $display("timeout: %s did not raise halted within %0d cycles", test_name,
                halt_timeout);
        end
    endtask

    task automatic finish_test();
        int n;
        check_value("store count", exp_addr.size(), st_addr_log.size());
        n = (exp_addr.size() < st_addr_log.size()) ? exp_addr.size() : st_addr_log.size();
        for (int k = 0; k < n; k++)
        begin
            check_value("store addr", exp_addr[k], st_addr_log[k]);
            check_value("store data", exp_data[k], st_data_log[k]);
        end
        check_value("fetch count", exp_fetch.size(), fetch_log.size());
        n = (exp_fetch.size() < fetch_log.size()) ? exp_fetch.size() : fetch_log.size();
        for (int k = 0; k < n; k++)
            check_value("fetch addr", exp_fetch[k], fetch_log[k]);
        test_count++;
        if (error_count == errors_at_start)
            $display("test %s: ok", test_name);
        else
            $display("test %s: %0d errors", test_name, error_count - errors_at_start);
    endtask

    task automatic test_ldi();
        logic [31:0] value;
        start_test("ldi");
        value = rand_word();
        put_const(3'd3, value);
        put_store(3'd3, 16'h0040);
        put_halt();
        expect_store(16'h0040, {value[31:16], value[15:0]});
        expect_linear();
        run_program();
        finish_test();
    endtask

    task automatic test_alu();
        logic [31:0] a;
        logic [31:0] b;
        start_test("alu");
        a = rand_word();
        b = rand_word();
        put_const(3'd1, a);
        put_const(3'd2, b);
        put_op_store(isa_pkg::op_add, 3'd3, 16'h0010, a + b);
        put_op_store(isa_pkg::op_sub, 3'd4, 16'h0011, a - b);
        put_op_store(isa_pkg::op_and, 3'd5, 16'h0012, a & b);
        put_op_store(isa_pkg::op_or, 3'd6, 16'h0013, a | b);
        put_op_store(isa_pkg::op_xor, 3'd7, 16'h0014, a ^ b);
        put_halt();
        expect_linear();
        run_program();
        finish_test();
    endtask

    // words 0 to 3 load r1 and r2 and a taken branch at 5 skips the store at 6
    task automatic test_branch(input bit equal);
        logic [31:0] a;
        logic [31:0] b;
        start_test(equal ? "branch_taken" : "branch_not_taken");
        a = rand_word();
        b = equal ? a : a ^ (rand_word() | 32'd1);
        put_const(3'd1, a);
        put_const(3'd2, b);
        emit(encode_reg(isa_pkg::op_cmpeq, 3'd1, 3'd2, 3'd5));
        emit(encode_imm(isa_pkg::op_brf, 3'd5, 3'd0, 1'b0, 16'd7));
        put_store(3'd1, 16'h0020);
        put_store(3'd2, 16'h0021);
        put_halt();
        if (!equal)
            expect_store(16'h0020, a);
        expect_store(16'h0021, b);
        for (int k = 0; k < 9; k++)
            if (!(equal && k == 6))
                exp_fetch.push_back(k[15:0]);
        run_program();
        finish_test();
    endtask

    task automatic test_backpressure();
        logic [31:0] a;
        logic [31:0] b;
        start_test("store_backpressure");
        st_stall = 20 + (rand_word() % 20);
        a = rand_word();
        b = rand_word();
        put_const(3'd1, a);
        put_store(3'd1, 16'h0030);
        put_const(3'd6, b);
        put_store(3'd6, 16'h0031);
        put_halt();
        expect_store(16'h0030, a);
        expect_store(16'h0031, b);
        expect_linear();
        run_program();
        st_stall = 0;
        finish_test();
    endtask

    // r4 and r7 were written by earlier programs and must read 0 after reset
    task automatic test_halt_reset();
        start_test("halt_reset");
        put_store(3'd4, 16'h0050);
        put_store(3'd7, 16'h0051);
        put_halt();
        expect_store(16'h0050, 32'd0);
        expect_store(16'h0051, 32'd0);
        expect_linear();
        run_program();
        repeat (20)
        begin
            @(posedge clear);
            check_value("halted", 32'd1, halted);
            check_value("imem_valid", 32'd0, imem_valid);
        end
        finish_test();
    endtask

    initial
    begin
        rst_n       = 1'b0;
        st_stall    = 0;
        error_count = 0;
        test_count  = 0;
        test_rng    = 32'd29;
        imem_rng    = lcg(test_rng);
        st_rng      = lcg(imem_rng);
        test_ldi();
        test_alu();
        test_halt_reset();
        test_branch(1'b1);
        test_branch(1'b0);
        test_backpressure();
        $display("tests run %0d, errors %0d", test_count, error_count);
        if (error_count == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* dv/tiny_core_assertions.sv */
`timescale 1ns/1ps

module tiny_core_assertions (
    input logic                        clear,
    input logic                        rst_n,
    input logic                        imem_valid,
    input logic                        imem_ready,
    input logic [core_pkg::addr_w-1:0] imem_addr,
    input logic                        st_valid,
    input logic                        st_ready,
    input logic [core_pkg::addr_w-1:0] st_addr,
    input logic [core_pkg::data_w-1:0] st_data,
    input logic                        halted,
    input core_pkg::state_e            state
);

    // a pending fetch keeps its address until memory takes it
    imem_hold: assert property (@(posedge clear) disable iff (!rst_n)
        imem_valid && !imem_ready |=> imem_valid && $stable(imem_addr))
        else $error("fetch request dropped or address changed before imem_ready");

    // a pending store keeps address and data until it is taken
    store_hold: assert property (@(posedge clear) disable iff (!rst_n)
        st_valid && !st_ready |=> st_valid && $stable(st_addr) && $stable(st_data))
        else $error("store dropped or changed before st_ready");

    reset_quiet: assert property (@(posedge clear)
        !rst_n |=> !imem_valid && !st_valid)
        else $error("valid output high during reset");

    // the halt state ends all fetching
    halt_quiet: assert property (@(posedge clear) disable iff (!rst_n)
        (halted || state == core_pkg::st_halt) |-> !imem_valid)
        else $error("fetch request made while halted");

endmodule

/* source/tiny_core.sv */
`timescale 1ns/1ps

module tiny_core (
    input  logic                        clear,
    input  logic                        rst_n,
    input  logic                        imem_ready,
    input  logic [core_pkg::data_w-1:0] imem_data,
    input  logic                        st_ready,
    output logic                        imem_valid,
    output logic [core_pkg::addr_w-1:0] imem_addr,
    output logic                        st_valid,
    output logic [core_pkg::addr_w-1:0] st_addr,
    output logic [core_pkg::data_w-1:0] st_data,
    output logic                        halted
);

    isa_pkg::instr_u             instr;
    logic                        fetch_en;
    logic                        exec_en;
    logic                        fetched;
    logic                        take_branch;
    logic [core_pkg::addr_w-1:0] branch_target;
    logic [core_pkg::data_w-1:0] rd_data_a;
    logic [core_pkg::data_w-1:0] rd_data_b;
    logic                        flag_q;
    logic [core_pkg::data_w-1:0] result;
    logic                        flag_out;
    logic                        reg_we;
    logic                        flag_we;
    logic                        is_store;
    logic                        is_halt;
    logic [isa_pkg::sel_w-1:0]   rd_sel_b;
    logic                        st_load;
    logic                        st_done;

    fetch_unit u_fetch (
        .clear         (clear),
        .rst_n         (rst_n),
        .fetch_en      (fetch_en),
        .exec_en       (exec_en),
        .take_branch   (take_branch),
        .branch_target (branch_target),
        .imem_ready    (imem_ready),
        .imem_data     (imem_data),
        .imem_valid    (imem_valid),
        .imem_addr     (imem_addr),
        .instr         (instr),
        .fetched       (fetched)
    );

    reg_file u_regs (
        .clear     (clear),
        .rst_n     (rst_n),
        .exec_en   (exec_en),
        .rd_sel_a  (instr.r.ra),
        .rd_sel_b  (rd_sel_b),
        .flag_sel  (instr.r.ra),
        .wr_sel    (instr.r.rd),
        .reg_we    (reg_we),
        .flag_we   (flag_we),
        .wr_data   (result),
        .wr_flag   (flag_out),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .flag_q    (flag_q)
    );

    // port b doubles as the old rd value for ldi
    alu u_alu (
        .instr         (instr),
        .rd_data_a     (rd_data_a),
        .rd_data_b     (rd_data_b),
        .flag_q        (flag_q),
        .old_rd        (rd_data_b),
        .result        (result),
        .flag_out      (flag_out),
        .reg_we        (reg_we),
        .flag_we       (flag_we),
        .take_branch   (take_branch),
        .branch_target (branch_target),
        .is_store      (is_store),
        .is_halt       (is_halt),
        .rd_sel_b      (rd_sel_b)
    );

    core_sequencer u_seq (
        .clear    (clear),
        .rst_n    (rst_n),
        .fetched  (fetched),
        .is_store (is_store),
        .is_halt  (is_halt),
        .st_done  (st_done),
        .fetch_en (fetch_en),
        .exec_en  (exec_en),
        .st_load  (st_load),
        .halted   (halted)
    );

    store_port u_store (
        .clear      (clear),
        .rst_n      (rst_n),
        .st_load    (st_load),
        .st_addr_in (instr.i.imm),
        .st_data_in (rd_data_a),
        .st_ready   (st_ready),
        .st_valid   (st_valid),
        .st_addr    (st_addr),
        .st_data    (st_data),
        .st_done    (st_done)
    );

endmodule

/* source/store_port.sv */
`timescale 1ns/1ps

module store_port (
    input  logic                        clear,
    input  logic                        rst_n,
    input  logic                        st_load,
    input  logic [core_pkg::addr_w-1:0] st_addr_in,
    input  logic [core_pkg::data_w-1:0] st_data_in,
    input  logic                        st_ready,
    output logic                        st_valid,
    output logic [core_pkg::addr_w-1:0] st_addr,
    output logic [core_pkg::data_w-1:0] st_data,
    output logic                        st_done
);

    assign st_done = st_valid && st_ready;

    // valid holds until the consumer takes the write
    always_ff @(posedge clear or negedge rst_n)
    begin
        if (!rst_n)
        begin
            st_valid <= 1'b0;
        end
        else if (st_load)
        begin
            st_valid <= 1'b1;
        end
        else if (st_done)
        begin
            st_valid <= 1'b0;
        end
    end

    // address and data only change on a new store
    always_ff @(posedge clear or negedge rst_n)
    begin
        if (!rst_n)
        begin
            st_addr <= '0;
            st_data <= '0;
        end
        else if (st_load)
        begin
            st_addr <= st_addr_in;
            st_data <= st_data_in;
        end
    end

endmodule

/* source/core_sequencer.sv */
`timescale 1ns/1ps

module core_sequencer (
    input  logic clear,
    input  logic rst_n,
    input  logic fetched,
    input  logic is_store,
    input  logic is_halt,
    input  logic st_done,
    output logic fetch_en,
    output logic exec_en,
    output logic st_load,
    output logic halted
);

    core_pkg::state_e state_q;
    core_pkg::state_e state_d;

    assign fetch_en = (state_q == core_pkg::st_fetch);
    assign exec_en  = (state_q == core_pkg::st_exec);

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            core_pkg::st_fetch:
            begin
                if (fetched)
                begin
                    state_d = core_pkg::st_exec;
                end
            end
            core_pkg::st_exec:
            begin
                if (is_halt)
                begin
                    state_d = core_pkg::st_halt;
                end
                else if (is_store)
                begin
                    state_d = core_pkg::st_store;
                end
                else
                begin
                    state_d = core_pkg::st_fetch;
                end
            end
            core_pkg::st_store:
            begin
                if (st_done)
                begin
                    state_d = core_pkg::st_fetch;
                end
            end
            default: state_d = core_pkg::st_halt;
        endcase
    end

    // st_load is high for the first cycle in st_store
    always_ff @(posedge clear or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q <= core_pkg::st_fetch;
            st_load <= 1'b0;
            halted  <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            st_load <= exec_en && is_store;
            halted  <= (state_q == core_pkg::st_halt);
        end
    end

endmodule

/* source/alu.sv */
`timescale 1ns/1ps

module alu (
    input  isa_pkg::instr_u             instr,
    input  logic [core_pkg::data_w-1:0] rd_data_a,
    input  logic [core_pkg::data_w-1:0] rd_data_b,
    input  logic                        flag_q,
    input  logic [core_pkg::data_w-1:0] old_rd,
    output logic [core_pkg::data_w-1:0] result,
    output logic                        flag_out,
    output logic                        reg_we,
    output logic                        flag_we,
    output logic                        take_branch,
    output logic [core_pkg::addr_w-1:0] branch_target,
    output logic                        is_store,
    output logic                        is_halt,
    output logic [isa_pkg::sel_w-1:0]   rd_sel_b
);

    isa_pkg::instr_r_t instr_r;
    isa_pkg::instr_i_t instr_i;

    assign instr_r = instr.r;
    assign instr_i = instr.i;

    // ldi needs the current rd value to keep the other half
    assign rd_sel_b = (instr_r.opcode == isa_pkg::op_ldi) ? instr_r.rd : instr_r.rb;

    assign flag_out      = (rd_data_a == rd_data_b);
    assign branch_target = instr_i.imm;
    assign take_branch   = (instr_i.opcode == isa_pkg::op_brf) && flag_q;
    assign is_store      = (instr_i.opcode == isa_pkg::op_store);
    assign is_halt       = (instr_i.opcode == isa_pkg::op_halt);
    assign flag_we       = (instr_r.opcode == isa_pkg::op_cmpeq);

    always_comb
    begin
        result = '0;
        reg_we = 1'b1;
        case (instr_r.opcode)
            isa_pkg::op_add: result = rd_data_a + rd_data_b;
            isa_pkg::op_sub: result = rd_data_a - rd_data_b;
            isa_pkg::op_and: result = rd_data_a & rd_data_b;
            isa_pkg::op_or:  result = rd_data_a | rd_data_b;
            isa_pkg::op_xor: result = rd_data_a ^ rd_data_b;
            isa_pkg::op_ldi:
            begin
                if (instr_i.hl)
                begin
                    result = {instr_i.imm, old_rd[15:0]};
                end
                else
                begin
                    result = {old_rd[31:16], instr_i.imm};
                end
            end
            default: reg_we = 1'b0;
        endcase
    end

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                        clear,
    input  logic                        rst_n,
    input  logic                        exec_en,
    input  logic [isa_pkg::sel_w-1:0]   rd_sel_a,
    input  logic [isa_pkg::sel_w-1:0]   rd_sel_b,
    input  logic [isa_pkg::sel_w-1:0]   flag_sel,
    input  logic [isa_pkg::sel_w-1:0]   wr_sel,
    input  logic                        reg_we,
    input  logic                        flag_we,
    input  logic [core_pkg::data_w-1:0] wr_data,
    input  logic                        wr_flag,
    output logic [core_pkg::data_w-1:0] rd_data_a,
    output logic [core_pkg::data_w-1:0] rd_data_b,
    output logic                        flag_q
);

    logic [core_pkg::data_w-1:0]   regs [core_pkg::num_regs];
    logic [core_pkg::num_regs-1:0] flags;

    // reads are combinational
    assign rd_data_a = regs[rd_sel_a];
    assign rd_data_b = regs[rd_sel_b];
    assign flag_q    = flags[flag_sel];

    // data and flag share the write select but have separate enables
    always_ff @(posedge clear or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < core_pkg::num_regs; i++)
            begin
                regs[i] <= '0;
            end
            flags <= '0;
        end
        else if (exec_en)
        begin
            if (reg_we)
            begin
                regs[wr_sel] <= wr_data;
            end
            if (flag_we)
            begin
                flags[wr_sel] <= wr_flag;
            end
        end
    end

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic                        clear,
    input  logic                        rst_n,
    input  logic                        fetch_en,
    input  logic                        exec_en,
    input  logic                        take_branch,
    input  logic [core_pkg::addr_w-1:0] branch_target,
    input  logic                        imem_ready,
    input  logic [core_pkg::data_w-1:0] imem_data,
    output logic                        imem_valid,
    output logic [core_pkg::addr_w-1:0] imem_addr,
    output isa_pkg::instr_u             instr,
    output logic                        fetched
);

    logic [core_pkg::addr_w-1:0] pc;

    assign imem_addr = pc;

    // one-cycle pulse on the instruction handshake
    assign fetched = imem_valid && imem_ready;

    // request is raised a cycle after fetch_en and held until ready
    always_ff @(posedge clear or negedge rst_n)
    begin
        if (!rst_n)
        begin
            imem_valid <= 1'b0;
        end
        else if (fetched)
        begin
            imem_valid <= 1'b0;
        end
        else if (fetch_en)
        begin
            imem_valid <= 1'b1;
        end
    end

    // pc moves only when the instruction executes
    always_ff @(posedge clear or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc <= '0;
        end
        else if (exec_en)
        begin
            if (take_branch)
            begin
                pc <= branch_target;
            end
            else
            begin
                pc <= pc + 1'b1;
            end
        end
    end

    // instruction register
    always_ff @(posedge clear or negedge rst_n)
    begin
        if (!rst_n)
        begin
            instr <= '0;
        end
        else if (fetched)
        begin
            instr <= imem_data;
        end
    end

endmodule

/* source/core_pkg.sv */
package core_pkg;

    // register and store data width
    localparam int data_w = 32;

    // program counter and store address width
    localparam int addr_w = 16;

    localparam int num_regs = 8;

    // sequencer states
    typedef enum logic [1:0] {
        st_fetch = 2'd0,
        st_exec  = 2'd1,
        st_store = 2'd2,
        st_halt  = 2'd3
    } state_e;

endpackage

/* source/isa_pkg.sv */
package isa_pkg;

    localparam int opcode_w = 6;
    localparam int sel_w    = 3;
    localparam int imm_w    = 16;

    // codes not listed here execute as a no-op
    typedef enum logic [opcode_w-1:0] {
        op_add   = 6'h01,
        op_sub   = 6'h02,
        op_and   = 6'h03,
        op_or    = 6'h04,
        op_xor   = 6'h05,
        op_ldi   = 6'h06,
        op_cmpeq = 6'h07,
        op_brf   = 6'h08,
        op_store = 6'h09,
        op_halt  = 6'h3f
    } opcode_e;

    // register form
    // the upper 17 bits are unused here
    typedef struct packed {
        logic [imm_w:0]   spare;
        logic [sel_w-1:0] rd;
        logic [sel_w-1:0] rb;
        logic [sel_w-1:0] ra;
        opcode_e          opcode;
    } instr_r_t;

    // in immediate form hl picks the half written by op_ldi
    typedef struct packed {
        logic [imm_w-1:0] imm;
        logic             hl;
        logic [sel_w-1:0] rd;
        logic [sel_w-1:0] rb;
        logic [sel_w-1:0] ra;
        opcode_e          opcode;
    } instr_i_t;

    // both views share the opcode and selector fields at the bottom
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

endpackage
